// ==== source/elinkBridge_config.svh ====
/* elink bridge configuration
   register map, message width and payload limits shared by all blocks */

`ifndef ELINKBRIDGE_CONFIG_SVH
`define ELINKBRIDGE_CONFIG_SVH

// CAN controller register bank addressing
`define REG_ADDR_WIDTH 5

// transmit message registers sit at 2..11
`define REG_FIRST_ADDR 2
`define REG_COUNT 10

// ten registers minus the low nibble of the last one
`define MSG_WIDTH 76

// payload bytes carried by one message, larger DLC values are clamped
`define MAX_PAYLOAD 7

`endif

// ==== source/elinkBridgePkg.sv ====
/* elink bridge types
   transmit message word with its field view, serializer states */

`include "elinkBridge_config.svh"

package elinkBridgePkg;

   // field layout of the buffered message, MSB first
   typedef struct packed
   {
      logic [10:0]                 cobId;    // CAN identifier
      logic                        rtr;      // remote request
      logic [3:0]                  dlc;      // data length code
      logic [8*`MAX_PAYLOAD-1:0]   payload;  // first payload byte uppermost
      logic [3:0]                  tail;     // status flags
   } canTraFields;

   /* the buffer fills the word as raw register bytes,
      the serializer reads it back through fields */
   typedef union packed
   {
      logic [`MSG_WIDTH-1:0] raw;
      canTraFields           fields;
   } canTraMsg;

   // byte currently on the elink
   typedef enum logic [2:0]
   {
      idle,
      header0,    // cobId[10:3]
      header1,    // cobId[2:0], rtr, dlc
      payload,
      tail
   } serState;

endpackage

// ==== source/canRegReader.sv ====
/* CAN register reader
   walks the transmit registers and lines up buffer writes with read data */

`timescale 1ns/1ps
`include "elinkBridge_config.svh"

module canRegReader
(
   input  logic                       clk,
   input  logic                       rst,        // active low
   input  logic                       start,      // one cycle pulse
   input  logic                       txBusy,     // serializer still sending
   output logic [`REG_ADDR_WIDTH-1:0] regAddr,
   output logic                       regRead,
   output logic                       bufEn,
   output logic [`REG_ADDR_WIDTH-1:0] bufAddr,
   output logic                       msgReady,
   output logic                       busy
);

   localparam int cntWidth = $clog2(`REG_COUNT);

   localparam logic [`REG_ADDR_WIDTH-1:0] firstAddr = `REG_ADDR_WIDTH'(`REG_FIRST_ADDR);
   localparam logic [`REG_ADDR_WIDTH-1:0] lastAddr =
      `REG_ADDR_WIDTH'(`REG_FIRST_ADDR + `REG_COUNT - 1);
   localparam logic [cntWidth-1:0] lastCnt = cntWidth'(`REG_COUNT - 1);

   logic [cntWidth-1:0] readCnt;   // register index within the message
   logic                readerBusy;
   logic                startOk;

   // reader is busy from the first read until msgReady has gone out
   assign readerBusy = regRead | bufEn | msgReady;
   assign startOk    = start & ~readerBusy & ~txBusy;

   assign regAddr = firstAddr + `REG_ADDR_WIDTH'(readCnt);
   assign busy    = readerBusy | txBusy;

   // read sequencer
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         regRead <= 1'b0;
         readCnt <= '0;
      end
      else if (startOk)
      begin
         regRead <= 1'b1;
         readCnt <= '0;
      end
      else if (regRead)
      begin
         if (readCnt == lastCnt)
         begin
            regRead <= 1'b0;   // all ten issued
         end
         else
         begin
            readCnt <= readCnt + cntWidth'(1);
         end
      end
   end

   /* the bank answers one cycle after regRead, so the write
      strobe and address are the read side delayed by one stage */
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         bufEn   <= 1'b0;
         bufAddr <= '0;
      end
      else
      begin
         bufEn   <= regRead;
         bufAddr <= regAddr;
      end
   end

   // message complete one cycle after the last byte lands
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         msgReady <= 1'b0;
      end
      else
      begin
         msgReady <= bufEn && (bufAddr == lastAddr);
      end
   end

endmodule

// ==== source/canMessageBuffer.sv ====
/* CAN transmit message buffer
   captures register bytes by address into the 76-bit message word */

`timescale 1ns/1ps
`include "elinkBridge_config.svh"

module canMessageBuffer
(
   input  logic                       clk,
   input  logic                       rst,       // active low
   input  logic                       bufEn,     // write strobe, aligned with regData
   input  logic [`REG_ADDR_WIDTH-1:0] bufAddr,
   input  logic [7:0]                 regData,
   output elinkBridgePkg::canTraMsg   msg
);

   localparam logic [`REG_ADDR_WIDTH-1:0] firstAddr = `REG_ADDR_WIDTH'(`REG_FIRST_ADDR);

   logic [7:0]            byteReg [`REG_COUNT];   // byte 0 holds cobId[10:3]
   logic [`REG_COUNT-1:0] wrSel;

   // one hot address decode, addresses outside 2..11 select nothing
   always_comb
   begin
      for (int i = 0; i < `REG_COUNT; i++)
      begin
         wrSel[i] = bufEn && (bufAddr == firstAddr + `REG_ADDR_WIDTH'(i));
      end
   end

   // buffer reads as zero after reset
   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         for (int i = 0; i < `REG_COUNT; i++)
         begin
            byteReg[i] <= 8'h00;
         end
      end
      else
      begin
         for (int i = 0; i < `REG_COUNT; i++)
         begin
            if (wrSel[i])
            begin
               byteReg[i] <= regData;
            end
         end
      end
   end

   /* raw view of the message, low nibble of the last register
      carries nothing and is dropped */
   always_comb
   begin
      msg.raw = {byteReg[0],
                 byteReg[1],
                 byteReg[2],
                 byteReg[3],
                 byteReg[4],
                 byteReg[5],
                 byteReg[6],
                 byteReg[7],
                 byteReg[8],
                 byteReg[9][7:4]};
   end

endmodule

// ==== source/elinkFrameSerializer.sv ====
/* elink frame serializer
   sends header, DLC-sized payload and tail of a buffered message as bytes */

`timescale 1ns/1ps
`include "elinkBridge_config.svh"

module elinkFrameSerializer
(
   input  logic                     clk,
   input  logic                     rst,        // active low
   input  logic                     msgReady,   // buffer holds a full message
   input  elinkBridgePkg::canTraMsg msg,
   output logic [7:0]               elinkData,
   output logic                     elinkValid,
   output logic                     elinkSof,
   output logic                     elinkEof,
   output logic                     txBusy
);

   elinkBridgePkg::serState  state;
   elinkBridgePkg::canTraMsg msgReg;     // frozen copy while sending
   logic [2:0]               payLen;     // payload bytes in this frame
   logic [2:0]               payIdx;
   logic [7:0]               payByte;

   // remote frames carry no data, dlc above 7 is clamped
   always_comb
   begin
      if (msgReg.fields.rtr)
      begin
         payLen = 3'd0;
      end
      else if (msgReg.fields.dlc > 4'(`MAX_PAYLOAD))
      begin
         payLen = 3'(`MAX_PAYLOAD);
      end
      else
      begin
         payLen = msgReg.fields.dlc[2:0];
      end
   end

   assign payByte = msgReg.fields.payload[(`MAX_PAYLOAD - 1 - int'(payIdx)) * 8 +: 8];

   always_ff @(posedge clk)
   begin
      if (state == elinkBridgePkg::idle && msgReady)
      begin
         msgReg <= msg;
      end
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state  <= elinkBridgePkg::idle;
         payIdx <= '0;
      end
      else
      begin
         case (state)
            elinkBridgePkg::idle:
               if (msgReady) state <= elinkBridgePkg::header0;
            elinkBridgePkg::header0:
               state <= elinkBridgePkg::header1;
            elinkBridgePkg::header1:
            begin
               payIdx <= '0;
               state  <= (payLen == 3'd0) ? elinkBridgePkg::tail : elinkBridgePkg::payload;
            end
            elinkBridgePkg::payload:
               if (payIdx == payLen - 3'd1) state <= elinkBridgePkg::tail;
               else payIdx <= payIdx + 3'd1;
            default:
               state <= elinkBridgePkg::idle;   // tail is the last byte
         endcase
      end
   end

   // byte on the link follows the state directly
   always_comb
   begin
      case (state)
         elinkBridgePkg::header0: elinkData = msgReg.fields.cobId[10:3];
         elinkBridgePkg::header1:
            elinkData = {msgReg.fields.cobId[2:0], msgReg.fields.rtr, msgReg.fields.dlc};
         elinkBridgePkg::payload: elinkData = payByte;
         elinkBridgePkg::tail:    elinkData = {msgReg.fields.tail, 4'h0};
         default:                 elinkData = 8'h00;
      endcase
   end

   assign elinkValid = (state != elinkBridgePkg::idle);
   assign elinkSof   = (state == elinkBridgePkg::header0);
   assign elinkEof   = (state == elinkBridgePkg::tail);
   assign txBusy     = elinkValid;   // high through the last byte

endmodule

// ==== source/canElinkBridge.sv ====
/* CAN to elink bridge top level
   register reader, message buffer and frame serializer */

`timescale 1ns/1ps
`include "elinkBridge_config.svh"

module canElinkBridge
(
   input  logic                       clk,
   input  logic                       rst,         // active low
   input  logic                       start,       // one cycle pulse
   output logic                       busy,
   output logic [`REG_ADDR_WIDTH-1:0] regAddr,     // to the CAN register bank
   output logic                       regRead,
   input  logic [7:0]                 regData,     // one cycle after regRead
   output logic [7:0]                 elinkData,
   output logic                       elinkValid,
   output logic                       elinkSof,
   output logic                       elinkEof
);

   logic                       bufEn;
   logic [`REG_ADDR_WIDTH-1:0] bufAddr;
   logic                       msgReady;
   logic                       txBusy;
   elinkBridgePkg::canTraMsg   msg;

   canRegReader reader
   (
      .clk      (clk),
      .rst      (rst),
      .start    (start),
      .txBusy   (txBusy),
      .regAddr  (regAddr),
      .regRead  (regRead),
      .bufEn    (bufEn),
      .bufAddr  (bufAddr),
      .msgReady (msgReady),
      .busy     (busy)
   );

   canMessageBuffer buffer
   (
      .clk     (clk),
      .rst     (rst),
      .bufEn   (bufEn),
      .bufAddr (bufAddr),
      .regData (regData),
      .msg     (msg)
   );

   // serializer picks up the message the cycle after the last write
   elinkFrameSerializer serializer
   (
      .clk        (clk),
      .rst        (rst),
      .msgReady   (msgReady),
      .msg        (msg),
      .elinkData  (elinkData),
      .elinkValid (elinkValid),
      .elinkSof   (elinkSof),
      .elinkEof   (elinkEof),
      .txBusy     (txBusy)
   );

endmodule

// ==== bench/canElinkBridgeTb.sv ====
/* CAN to elink bridge testbench
   register bank model, directed and random messages, byte level checking */

`timescale 1ns/1ps
`include "elinkBridge_config.svh"

module canElinkBridgeTb;

   localparam int numMessages    = 57;   // 7 directed plus 50 random
   localparam int resetCycles    = 10;
   localparam int cycleLimit     = 40 * numMessages + resetCycles;
   localparam int firstByteDelay = 13;   // start edge to first elink byte

   logic                       clk;
   logic                       rst;
   logic                       start;
   logic                       busy;
   logic [`REG_ADDR_WIDTH-1:0] regAddr;
   logic                       regRead;
   logic [7:0]                 regData;
   logic [7:0]                 elinkData;
   logic                       elinkValid;
   logic                       elinkSof;
   logic                       elinkEof;

   logic [7:0]                 bank [32];    // CAN controller register bank
   logic                       readPending;
   logic [`REG_ADDR_WIDTH-1:0] readAddr;
   logic [9:0]                 expQ [$];     // {sof, eof, data}
   string                      testName;
   int                         cycle;
   int                         checkCount;
   int                         errorCount;
   integer                     seed;

   canElinkBridge DUT
   (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .busy       (busy),
      .regAddr    (regAddr),
      .regRead    (regRead),
      .regData    (regData),
      .elinkData  (elinkData),
      .elinkValid (elinkValid),
      .elinkSof   (elinkSof),
      .elinkEof   (elinkEof)
   );

   initial
   begin
      clk = 1'b0;
   end

   always #2 clk = ~clk;

   // run limit
   always @(posedge clk)
   begin
      cycle <= cycle + 1;
      if (cycle >= cycleLimit)
      begin
         $display("timeout: run did not finish within %0d cycles", cycleLimit);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   // bank latches the read on the clock and drives data on the next falling edge
   always @(posedge clk)
   begin
      readPending <= regRead;
      readAddr    <= regAddr;
   end

   always @(negedge clk)
   begin
      if (readPending)
      begin
         regData = bank[readAddr];
      end
   end

   task automatic checkValue(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
      checkCount++;
      if (expected !== actual)
      begin
         errorCount++;
         $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   /* expected elink bytes from the ten register bytes
      with byte 0 uppermost in regs and the first elink byte uppermost in frame */
   function automatic int refFrame(input logic [79:0] regs, output logic [79:0] frame);
      logic [10:0] cobId;
      logic        rtr;
      logic [3:0]  dlc;
      logic [3:0]  status;
      int          payCount;
      cobId    = regs[79:69];
      rtr      = regs[68];
      dlc      = regs[67:64];
      status   = regs[7:4];   // low nibble of the last register is not sent
      payCount = rtr ? 0 : ((dlc > 4'd7) ? 7 : int'(dlc));
      frame    = '0;
      frame[79:72] = cobId[10:3];
      frame[71:64] = {cobId[2:0], rtr, dlc};
      for (int k = 0; k < payCount; k++)
      begin
         frame[63 - 8 * k -: 8] = regs[63 - 8 * k -: 8];
      end
      frame[63 - 8 * payCount -: 8] = {status, 4'h0};
      return 3 + payCount;
   endfunction

   // register image from message fields
   function automatic logic [79:0] makeRegs(input logic [10:0] cobId, input logic rtr,
                                            input logic [3:0] dlc, input logic [55:0] data,
                                            input logic [3:0] status);
      return {cobId, rtr, dlc, data, status, 4'h5};
   endfunction

   // every elink byte against the head of the expected queue
   always @(negedge clk)
   begin : compareBytes
      logic [9:0] expected;
      if (elinkValid)
      begin
         if (expQ.size() == 0)
         begin
            errorCount++;
            $display("%s: elink byte %h sent while no frame was expected", testName, elinkData);
         end
         else
         begin
            expected = expQ.pop_front();
            checkValue({testName, " data"}, 32'(expected[7:0]), 32'(elinkData));
            checkValue({testName, " sof"}, 32'(expected[9]), 32'(elinkSof));
            checkValue({testName, " eof"}, 32'(expected[8]), 32'(elinkEof));
         end
      end
      else
      begin
         checkValue({testName, " strobes without valid"}, 0, 32'({elinkSof, elinkEof}));
      end
   end

   // load the bank, pulse start and follow the message until busy drops
   task automatic sendMessage(input string name, input logic [79:0] regs,
                              input bit extraStarts);
      logic [79:0] frame;
      int          frameLen;
      int          startCycle;
      int          offset;
      int          firstByte;
      testName = name;
      for (int i = 0; i < `REG_COUNT; i++)
      begin
         bank[`REG_FIRST_ADDR + i] = regs[79 - 8 * i -: 8];
      end
      frameLen = refFrame(regs, frame);
      for (int j = 0; j < frameLen; j++)
      begin
         expQ.push_back({j == 0, j == frameLen - 1, frame[79 - 8 * j -: 8]});
      end
      firstByte = 0;
      @(negedge clk);
      start      = 1'b1;
      startCycle = cycle;
      do
      begin
         @(negedge clk);
         offset = cycle - startCycle;
         start  = extraStarts && (offset == 5 || offset == 14);   // both land while busy
         if (offset <= `REG_COUNT)
         begin
            checkValue({name, " regRead"}, 1, 32'(regRead));
            checkValue({name, " regAddr"}, `REG_FIRST_ADDR + offset - 1, 32'(regAddr));
         end
         else
         begin
            checkValue({name, " regRead after reads"}, 0, 32'(regRead));
         end
         if (elinkValid && firstByte == 0)
         begin
            firstByte = offset;
         end
      end
      while (busy);
      checkValue({name, " first byte delay"}, firstByteDelay, firstByte);
      checkValue({name, " busy low after frame"}, firstByteDelay + frameLen, offset);
      checkValue({name, " bytes missing"}, 0, expQ.size());
   endtask

   task automatic idleCheck(input string name, input int cycles);
      testName = name;
      repeat (cycles)
      begin
         @(negedge clk);
         checkValue({name, " quiet"}, 0,
                    32'({busy, regRead, elinkValid, elinkSof, elinkEof}));
      end
   endtask

   initial
   begin
      seed        = 32'h9a8e5737;
      cycle       = 0;
      checkCount  = 0;
      errorCount  = 0;
      testName    = "reset";
      rst         = 1'b0;
      start       = 1'b0;
      regData     = 8'h00;
      readPending = 1'b0;
      readAddr    = '0;
      for (int a = 0; a < 32; a++)
      begin
         bank[a] = 8'($random(seed));
      end
      repeat (resetCycles) @(negedge clk);
      rst = 1'b1;

      idleCheck("idle after reset", 20);

      sendMessage("dlc 7 data frame", makeRegs(11'h5a3, 1'b0, 4'd7, 56'h11223344556677, 4'hc),
                  1'b0);
      sendMessage("dlc 0", makeRegs(11'h7ff, 1'b0, 4'd0, 56'hdeadbeef012345, 4'h3), 1'b0);
      sendMessage("dlc 3", makeRegs(11'h001, 1'b0, 4'd3, 56'ha1b2c3d4e5f607, 4'h9), 1'b0);
      sendMessage("dlc 15 clamped", makeRegs(11'h2c4, 1'b0, 4'd15, 56'h0f1e2d3c4b5a69, 4'hf),
                  1'b0);
      sendMessage("remote frame", makeRegs(11'h155, 1'b1, 4'd5, 56'h99887766554433, 4'h6),
                  1'b0);
      sendMessage("read timing", makeRegs(11'h3a9, 1'b0, 4'd2, 56'h5aa55aa55aa55a, 4'h1), 1'b0);

      // extra start pulses must not produce a second frame
      sendMessage("start while busy", makeRegs(11'h6b2, 1'b0, 4'd7, 56'hcafef00d123456, 4'ha),
                  1'b1);
      idleCheck("no second frame", 20);

      for (int n = 0; n < 50; n++)
      begin
         sendMessage($sformatf("random %0d", n),
                     {32'($random(seed)), 32'($random(seed)), 16'($random(seed))}, 1'b0);
      end

      $display("summary: %0d checks, %0d errors", checkCount, errorCount);
      if (errorCount == 0)
      begin
         $display("ALL CHECKS PASSED");
      end
      else
      begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+source
source/elinkBridgePkg.sv
source/canRegReader.sv
source/canMessageBuffer.sv
source/elinkFrameSerializer.sv
source/canElinkBridge.sv
bench/canElinkBridgeTb.sv

// ==== Makefile ====
# Verilator lint and simulation for the CAN to elink bridge

VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= canElinkBridgeTb
RTL_TOP   ?= canElinkBridge
BUILD_DIR ?= obj_dir
SIM_BIN   ?= simv
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(SIM_BIN)
	@out="$$(./$(BUILD_DIR)/$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
